//--- serial_exec.f
rtl/serial_exec_pkg.sv
rtl/exec_sequencer.sv
rtl/serial_regfile.sv
rtl/serial_alu.sv
rtl/serial_exec_top.sv
testbench/serial_exec_sva.sv
testbench/serial_exec_tb.sv

//--- Bender.yml
package:
  name: serial_exec

sources:
  - files:
      - rtl/serial_exec_pkg.sv
      - rtl/exec_sequencer.sv
      - rtl/serial_regfile.sv
      - rtl/serial_alu.sv
      - rtl/serial_exec_top.sv

  - target: any(simulation, test)
    files:
      - testbench/serial_exec_sva.sv
      - testbench/serial_exec_tb.sv

//--- testbench/serial_exec_tb.sv
`timescale 1ns/1ps

module serial_exec_tb;
   import serial_exec_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_DIRECTED = 24;
   localparam int NUM_RANDOM   = 40;
   localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
   // Longest op is 10 cycles plus start and idle checks, doubled for margin
   localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_OPS * 12) * CLK_PERIOD * 2;
   localparam logic [31:0] LFSR_SEED = 32'h958dd4a3;

   typedef struct packed {
      alu_op_e   op;
      logic      use_imm;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      word_t     imm;
      word_t     expected;
   } vector_t;

   logic      clk;
   logic      i_rst_n;
   logic      i_start;
   alu_op_e   i_op;
   logic      i_use_imm;
   reg_addr_t i_rs1;
   reg_addr_t i_rs2;
   reg_addr_t i_rd;
   word_t     i_imm;
   logic      o_busy;
   logic      o_done;
   word_t     o_result;

   vector_t     vectors [NUM_DIRECTED];
   word_t       model_regs [NUM_REGS];
   logic [31:0] lfsr_state;
   int          error_count = 0;
   int          test_count  = 0;
   int          fail_count  = 0;
   int          done_count  = 0;

   serial_exec_top u_dut (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_start   (i_start),
      .i_op      (i_op),
      .i_use_imm (i_use_imm),
      .i_rs1     (i_rs1),
      .i_rs2     (i_rs2),
      .i_rd      (i_rd),
      .i_imm     (i_imm),
      .o_busy    (o_busy),
      .o_done    (o_done),
      .o_result  (o_result)
   );

   bind serial_exec_top serial_exec_sva u_sva (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_start (i_start),
      .o_busy  (o_busy),
      .o_done  (o_done)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // Completions seen on the falling edge
   always @(negedge clk) begin
      if (o_done) begin
         done_count++;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish in %0d ns, o_done never arrived", TIMEOUT_NS);
      $display("Errors found");
      $finish;
   end

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("MISMATCH at %0t: %s expected %h, actual %h", $time, name, expected, actual);
         error_count++;
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output word_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[XLEN-2:0], lfsr_state[31]};
         lfsr_state = next_lfsr(lfsr_state);
      end
   endtask

   function automatic word_t expected_result(input alu_op_e op, input word_t a, input word_t b);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
         default: return '0;
      endcase
   endfunction

   task automatic set_vector(input int idx, input alu_op_e op, input logic use_imm,
                             input reg_addr_t rs1, input reg_addr_t rs2, input reg_addr_t rd,
                             input word_t imm, input word_t expected);
      vectors[idx] = {op, use_imm, rs1, rs2, rd, imm, expected};
   endtask

   task automatic issue_start(input alu_op_e op, input logic use_imm, input reg_addr_t rs1,
                              input reg_addr_t rs2, input reg_addr_t rd, input word_t imm);
      @(posedge clk);
      i_start   <= 1'b1;
      i_op      <= op;
      i_use_imm <= use_imm;
      i_rs1     <= rs1;
      i_rs2     <= rs2;
      i_rd      <= rd;
      i_imm     <= imm;
      @(posedge clk);
      i_start   <= 1'b0;
   endtask

   task automatic wait_busy();
      @(negedge clk);
      while (!o_busy) @(negedge clk);
   endtask

   task automatic wait_done();
      @(negedge clk);
      while (!o_done) @(negedge clk);
   endtask

   task automatic report_test(input string label, input int errors_before);
      test_count++;
      if (error_count == errors_before) begin
         $display("test %0d pass: %s", test_count, label);
      end else begin
         fail_count++;
         $display("test %0d FAIL: %s", test_count, label);
      end
   endtask

   task automatic run_test(input alu_op_e op, input logic use_imm, input reg_addr_t rs1,
                           input reg_addr_t rs2, input reg_addr_t rd, input word_t imm,
                           input word_t expected, input logic interfere);
      int    errors_before;
      int    dones_before;
      string label;
      errors_before = error_count;
      issue_start(op, use_imm, rs1, rs2, rd, imm);
      dones_before = done_count;
      if (interfere) begin
         wait_busy();
         // Would clobber rd if it were taken
         issue_start(OP_XOR, 1'b1, rd, rd, rd, ~expected);
      end
      wait_done();
      check_value("o_result", expected, o_result);
      if (interfere) begin
         repeat (12) @(negedge clk);
         check_value("done_count", word_t'(dones_before + 1), word_t'(done_count));
         check_value("o_result", expected, o_result);
      end
      if (rd != '0) begin
         model_regs[rd] = expected;
      end
      if (use_imm) begin
         label = $sformatf("%s x%0d = x%0d, imm %h -> %h", op.name(), rd, rs1, imm, o_result);
      end else begin
         label = $sformatf("%s x%0d = x%0d, x%0d -> %h", op.name(), rd, rs1, rs2, o_result);
      end
      if (interfere) begin
         label = {label, " (start while busy)"};
      end
      report_test(label, errors_before);
   endtask

   task automatic load_vectors();
      // Loads through x0, including one aimed at x0 itself
      set_vector(0,  OP_ADD,  1'b1, 5'd0,  5'd0, 5'd1,  32'h0000_0005, 32'h0000_0005);
      set_vector(1,  OP_ADD,  1'b1, 5'd0,  5'd0, 5'd2,  32'hFFFF_FFFF, 32'hFFFF_FFFF);
      set_vector(2,  OP_ADD,  1'b1, 5'd0,  5'd0, 5'd3,  32'h1234_5678, 32'h1234_5678);
      set_vector(3,  OP_ADD,  1'b1, 5'd0,  5'd0, 5'd4,  32'h8000_0000, 32'h8000_0000);
      set_vector(4,  OP_ADD,  1'b1, 5'd0,  5'd0, 5'd0,  32'hDEAD_BEEF, 32'hDEAD_BEEF);
      set_vector(5,  OP_ADD,  1'b0, 5'd0,  5'd1, 5'd5,  32'h0000_0000, 32'h0000_0005);
      // Carry through all eight slices
      set_vector(6,  OP_ADD,  1'b1, 5'd2,  5'd0, 5'd6,  32'h0000_0001, 32'h0000_0000);
      set_vector(7,  OP_ADD,  1'b0, 5'd2,  5'd1, 5'd6,  32'h0000_0000, 32'h0000_0004);
      set_vector(8,  OP_SUB,  1'b0, 5'd1,  5'd3, 5'd7,  32'h0000_0000, 32'hEDCB_A98D);
      set_vector(9,  OP_SUB,  1'b1, 5'd3,  5'd0, 5'd7,  32'h0000_0678, 32'h1234_5000);
      set_vector(10, OP_SUB,  1'b0, 5'd0,  5'd1, 5'd8,  32'h0000_0000, 32'hFFFF_FFFB);
      set_vector(11, OP_AND,  1'b1, 5'd3,  5'd0, 5'd9,  32'h0F0F_F0F0, 32'h0204_5070);
      set_vector(12, OP_OR,   1'b0, 5'd3,  5'd4, 5'd10, 32'h0000_0000, 32'h9234_5678);
      set_vector(13, OP_XOR,  1'b0, 5'd3,  5'd2, 5'd3,  32'h0000_0000, 32'hEDCB_A987);
      set_vector(14, OP_AND,  1'b1, 5'd3,  5'd0, 5'd3,  32'hFFFF_0000, 32'hEDCB_0000);
      set_vector(15, OP_OR,   1'b1, 5'd1,  5'd0, 5'd1,  32'h0000_0030, 32'h0000_0035);
      // Pairs where signed and unsigned order disagree
      set_vector(16, OP_SLT,  1'b0, 5'd4,  5'd1, 5'd11, 32'h0000_0000, 32'h0000_0001);
      set_vector(17, OP_SLTU, 1'b0, 5'd4,  5'd1, 5'd12, 32'h0000_0000, 32'h0000_0000);
      set_vector(18, OP_SLT,  1'b0, 5'd1,  5'd2, 5'd13, 32'h0000_0000, 32'h0000_0000);
      set_vector(19, OP_SLTU, 1'b0, 5'd1,  5'd2, 5'd14, 32'h0000_0000, 32'h0000_0001);
      set_vector(20, OP_SLT,  1'b0, 5'd2,  5'd2, 5'd15, 32'h0000_0000, 32'h0000_0000);
      set_vector(21, OP_SLTU, 1'b1, 5'd0,  5'd0, 5'd15, 32'h0000_0001, 32'h0000_0001);
      set_vector(22, OP_SLT,  1'b1, 5'd4,  5'd0, 5'd4,  32'h7FFF_FFFF, 32'h0000_0001);
      set_vector(23, OP_ADD,  1'b0, 5'd6,  5'd8, 5'd16, 32'h0000_0000, 32'hFFFF_FFFF);
   endtask

   initial begin
      int        errors_before;
      word_t     bits;
      word_t     imm;
      alu_op_e   op;
      logic      use_imm;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      for (int i = 0; i < NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      lfsr_state = LFSR_SEED;
      load_vectors();
      i_rst_n   <= 1'b0;
      i_start   <= 1'b0;
      i_op      <= OP_ADD;
      i_use_imm <= 1'b0;
      i_rs1     <= '0;
      i_rs2     <= '0;
      i_rd      <= '0;
      i_imm     <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      i_rst_n <= 1'b1;
      @(negedge clk);

      errors_before = error_count;
      check_value("o_busy", '0, word_t'(o_busy));
      check_value("o_done", '0, word_t'(o_done));
      check_value("o_result", '0, o_result);
      report_test("state after reset", errors_before);

      for (int i = 0; i < NUM_DIRECTED; i++) begin
         run_test(vectors[i].op, vectors[i].use_imm, vectors[i].rs1, vectors[i].rs2,
                  vectors[i].rd, vectors[i].imm, vectors[i].expected, 1'b0);
      end

      for (int n = 0; n < NUM_RANDOM; n++) begin
         take_bits(3, bits);
         op = alu_op_e'(bits[2:0] % 3'd7);
         take_bits(1, bits);
         use_imm = bits[0];
         take_bits(5, bits);
         rs1 = bits[4:0];
         take_bits(5, bits);
         rs2 = bits[4:0];
         take_bits(5, bits);
         rd = bits[4:0];
         take_bits(32, imm);
         bits = expected_result(op, model_regs[rs1], use_imm ? imm : model_regs[rs2]);
         run_test(op, use_imm, rs1, rs2, rd, imm, bits, (n % 10) == 5);
      end

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
               test_count, test_count - fail_count, fail_count, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- testbench/serial_exec_sva.sv
`timescale 1ns/1ps

module serial_exec_sva (
   input logic clk,
   input logic i_rst_n,
   input logic i_start,
   input logic o_busy,
   input logic o_done
);

   logic prev_accept;
   logic start_ok;

   // Busy only rises one cycle after an accepted start
   assign start_ok = i_start && !o_busy && !prev_accept;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         prev_accept <= 1'b0;
      end else begin
         prev_accept <= start_ok;
      end
   end

   a_done_pulse: assert property (
      @(posedge clk) disable iff (!i_rst_n) o_done |=> !o_done
   ) else $error("o_done high on two consecutive cycles");

   a_done_not_busy: assert property (
      @(posedge clk) disable iff (!i_rst_n) !(o_done && o_busy)
   ) else $error("o_done high while o_busy is high");

   // Done rises 9 or 10 edges after the start, seen one sample later
   a_done_latency: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      start_ok |=> !o_done [*9] ##1 (o_done or (!o_done ##1 o_done))
   ) else $error("o_done did not follow an accepted start after 9 or 10 cycles");

   a_reset_idle: assert property (
      @(posedge clk) $rose(i_rst_n) |-> (!o_busy && !o_done)
   ) else $error("o_busy or o_done high right after reset release");

endmodule

//--- rtl/serial_exec_top.sv
`timescale 1ns/1ps

module serial_exec_top (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_start,
   input  serial_exec_pkg::alu_op_e   i_op,
   input  logic                       i_use_imm,
   input  serial_exec_pkg::reg_addr_t i_rs1,
   input  serial_exec_pkg::reg_addr_t i_rs2,
   input  serial_exec_pkg::reg_addr_t i_rd,
   input  serial_exec_pkg::word_t     i_imm,
   output logic                       o_busy,
   output logic                       o_done,
   output serial_exec_pkg::word_t     o_result
);
   import serial_exec_pkg::*;

   alu_op_e   alu_op;
   logic      use_imm;
   slice_t    imm_slice;
   cnt_t      cnt;
   logic      cnt_en;
   logic      first;
   logic      cmp_stage;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t wr_addr;
   logic      wen;
   slice_t    wdata;
   slice_t    rs1;
   slice_t    rs2;
   slice_t    alu_rd;

   exec_sequencer u_seq (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_start     (i_start),
      .i_op        (i_op),
      .i_use_imm   (i_use_imm),
      .i_rs1       (i_rs1),
      .i_rs2       (i_rs2),
      .i_rd        (i_rd),
      .i_imm       (i_imm),
      .i_alu_rd    (alu_rd),
      .o_op        (alu_op),
      .o_use_imm   (use_imm),
      .o_imm_slice (imm_slice),
      .o_cnt       (cnt),
      .o_cnt_en    (cnt_en),
      .o_first     (first),
      .o_cmp_stage (cmp_stage),
      .o_rs1_addr  (rs1_addr),
      .o_rs2_addr  (rs2_addr),
      .o_wr_addr   (wr_addr),
      .o_wen       (wen),
      .o_wdata     (wdata),
      .o_busy      (o_busy),
      .o_done      (o_done),
      .o_result    (o_result)
   );

   serial_regfile u_rf (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_wr_addr  (wr_addr),
      .i_wen      (wen),
      .i_wdata    (wdata),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serial_alu u_alu (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_cnt_en    (cnt_en),
      .i_first     (first),
      .i_cmp_stage (cmp_stage),
      .i_op        (alu_op),
      .i_use_imm   (use_imm),
      .i_imm_slice (imm_slice),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .o_rd        (alu_rd)
   );

endmodule

//--- rtl/serial_alu.sv
`timescale 1ns/1ps

module serial_alu (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic                     i_cnt_en,
   input  logic                     i_first,
   input  logic                     i_cmp_stage,
   input  serial_exec_pkg::alu_op_e i_op,
   input  logic                     i_use_imm,
   input  serial_exec_pkg::slice_t  i_imm_slice,
   input  serial_exec_pkg::slice_t  i_rs1,
   input  serial_exec_pkg::slice_t  i_rs2,
   output serial_exec_pkg::slice_t  o_rd
);
   import serial_exec_pkg::*;

   slice_t                  op_b;
   slice_t                  b_eff;
   logic                    is_cmp;
   logic                    sub;
   logic                    carry_in;
   logic                    carry_r;
   logic                    cmp_r;
   logic                    lt_slice;
   logic [BITS_PER_CYCLE:0] sum;

   assign op_b   = i_use_imm ? i_imm_slice : i_rs2;
   assign is_cmp = (i_op == OP_SLT) || (i_op == OP_SLTU);
   assign sub    = (i_op == OP_SUB) || is_cmp;

   // Two's complement subtract: invert B, carry in of one on the first slice
   assign b_eff    = sub ? ~op_b : op_b;
   assign carry_in = i_first ? sub : carry_r;
   assign sum      = {1'b0, i_rs1} + {1'b0, b_eff} + {{BITS_PER_CYCLE{1'b0}}, carry_in};

   // Only the value from the top slice matters
   always_comb begin
      if (i_op == OP_SLTU) begin
         lt_slice = ~sum[BITS_PER_CYCLE];
      end else if (i_rs1[BITS_PER_CYCLE-1] != op_b[BITS_PER_CYCLE-1]) begin
         lt_slice = i_rs1[BITS_PER_CYCLE-1];
      end else begin
         lt_slice = ~sum[BITS_PER_CYCLE];
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_r <= 1'b0;
         cmp_r   <= 1'b0;
      end else if (i_cnt_en) begin
         carry_r <= sum[BITS_PER_CYCLE];
         cmp_r   <= lt_slice;
      end
   end

   always_comb begin
      case (i_op)
         OP_ADD,
         OP_SUB: begin
            o_rd = sum[BITS_PER_CYCLE-1:0];
         end
         OP_AND: begin
            o_rd = i_rs1 & op_b;
         end
         OP_OR: begin
            o_rd = i_rs1 | op_b;
         end
         OP_XOR: begin
            o_rd = i_rs1 ^ op_b;
         end
         OP_SLT,
         OP_SLTU: begin
            // Zeros while counting, flag in bit 0 on the extra cycle
            if (i_cmp_stage) begin
               o_rd = {{(BITS_PER_CYCLE-1){1'b0}}, cmp_r};
            end else begin
               o_rd = '0;
            end
         end
         default: begin
            o_rd = '0;
         end
      endcase
   end

endmodule

//--- rtl/serial_regfile.sv
`timescale 1ns/1ps

module serial_regfile (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  serial_exec_pkg::cnt_t      i_cnt,
   input  serial_exec_pkg::reg_addr_t i_rs1_addr,
   input  serial_exec_pkg::reg_addr_t i_rs2_addr,
   input  serial_exec_pkg::reg_addr_t i_wr_addr,
   input  logic                       i_wen,
   input  serial_exec_pkg::slice_t    i_wdata,
   output serial_exec_pkg::slice_t    o_rs1,
   output serial_exec_pkg::slice_t    o_rs2
);
   import serial_exec_pkg::*;

   // Entry index is register number on top of slice number
   logic [$bits(reg_addr_t)+$bits(cnt_t)-1:0] wr_idx;
   logic [$bits(reg_addr_t)+$bits(cnt_t)-1:0] rs1_idx;
   logic [$bits(reg_addr_t)+$bits(cnt_t)-1:0] rs2_idx;

   slice_t mem [NUM_REGS*SLICES];

   assign wr_idx  = {i_wr_addr, i_cnt};
   assign rs1_idx = {i_rs1_addr, i_cnt};
   assign rs2_idx = {i_rs2_addr, i_cnt};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NUM_REGS*SLICES; i++) begin
            mem[i] <= '0;
         end
      end else if (i_wen && (i_wr_addr != '0)) begin
         mem[wr_idx] <= i_wdata;
      end
   end

   // x0 is hardwired to zero
   assign o_rs1 = (i_rs1_addr == '0) ? '0 : mem[rs1_idx];
   assign o_rs2 = (i_rs2_addr == '0) ? '0 : mem[rs2_idx];

endmodule

//--- rtl/exec_sequencer.sv
`timescale 1ns/1ps

module exec_sequencer (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_start,
   input  serial_exec_pkg::alu_op_e   i_op,
   input  logic                       i_use_imm,
   input  serial_exec_pkg::reg_addr_t i_rs1,
   input  serial_exec_pkg::reg_addr_t i_rs2,
   input  serial_exec_pkg::reg_addr_t i_rd,
   input  serial_exec_pkg::word_t     i_imm,
   input  serial_exec_pkg::slice_t    i_alu_rd,
   output serial_exec_pkg::alu_op_e   o_op,
   output logic                       o_use_imm,
   output serial_exec_pkg::slice_t    o_imm_slice,
   output serial_exec_pkg::cnt_t      o_cnt,
   output logic                       o_cnt_en,
   output logic                       o_first,
   output logic                       o_cmp_stage,
   output serial_exec_pkg::reg_addr_t o_rs1_addr,
   output serial_exec_pkg::reg_addr_t o_rs2_addr,
   output serial_exec_pkg::reg_addr_t o_wr_addr,
   output logic                       o_wen,
   output serial_exec_pkg::slice_t    o_wdata,
   output logic                       o_busy,
   output logic                       o_done,
   output serial_exec_pkg::word_t     o_result
);
   import serial_exec_pkg::*;

   logic      armed;
   logic      run;
   logic      cmp_stage;
   logic      done;
   logic      busy;
   logic      accept;
   logic      last;
   logic      is_cmp;
   cnt_t      cnt;
   alu_op_e   op_r;
   logic      use_imm_r;
   reg_addr_t rs1_r;
   reg_addr_t rs2_r;
   reg_addr_t rd_r;
   word_t     imm_sr;
   word_t     acc;
   word_t     result;

   assign busy   = run | cmp_stage;
   // One idle cycle between accept and slice 0, so armed also blocks a start
   assign accept = i_start && !busy && !armed;
   assign last   = run && (cnt == cnt_t'(SLICES - 1));
   assign is_cmp = (op_r == OP_SLT) || (op_r == OP_SLTU);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         armed     <= 1'b0;
         run       <= 1'b0;
         cmp_stage <= 1'b0;
         done      <= 1'b0;
         cnt       <= '0;
         op_r      <= OP_ADD;
         use_imm_r <= 1'b0;
      end else begin
         done  <= 1'b0;
         armed <= accept;
         if (accept) begin
            op_r      <= i_op;
            use_imm_r <= i_use_imm;
         end
         if (armed) begin
            run <= 1'b1;
            cnt <= '0;
         end else if (run) begin
            cnt <= cnt + 1'b1;
            if (last) begin
               run       <= 1'b0;
               cmp_stage <= is_cmp;
               done      <= !is_cmp;
            end
         end
         // Compare result lands in slice 0 one cycle late
         if (cmp_stage) begin
            cmp_stage <= 1'b0;
            done      <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rs1_r  <= i_rs1;
         rs2_r  <= i_rs2;
         rd_r   <= i_rd;
         imm_sr <= i_imm;
      end else if (run) begin
         imm_sr <= imm_sr >> BITS_PER_CYCLE;
      end
      if (run) begin
         acc <= {i_alu_rd, acc[XLEN-1:BITS_PER_CYCLE]};
      end
   end

   // Result only changes on completion
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         result <= '0;
      end else if (last && !is_cmp) begin
         result <= {i_alu_rd, acc[XLEN-1:BITS_PER_CYCLE]};
      end else if (cmp_stage) begin
         result <= {acc[XLEN-1:BITS_PER_CYCLE], i_alu_rd};
      end
   end

   assign o_op        = op_r;
   assign o_use_imm   = use_imm_r;
   assign o_imm_slice = imm_sr[BITS_PER_CYCLE-1:0];
   assign o_cnt       = cnt;
   assign o_cnt_en    = run;
   assign o_first     = run && (cnt == '0);
   assign o_cmp_stage = cmp_stage;
   assign o_rs1_addr  = rs1_r;
   assign o_rs2_addr  = rs2_r;
   assign o_wr_addr   = rd_r;
   assign o_wen       = busy;
   assign o_wdata     = i_alu_rd;
   assign o_busy      = busy;
   assign o_done      = done;
   assign o_result    = result;

endmodule

//--- rtl/serial_exec_pkg.sv
package serial_exec_pkg;

   // Datapath geometry
   localparam int XLEN           = 32;
   localparam int BITS_PER_CYCLE = 4;
   localparam int SLICES         = XLEN / BITS_PER_CYCLE;
   localparam int NUM_REGS       = 32;

   typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
   typedef logic [XLEN-1:0]             word_t;
   typedef logic [BITS_PER_CYCLE-1:0]   slice_t;
   typedef logic [$clog2(SLICES)-1:0]   cnt_t;

   // Operation codes carried with each command
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_SLT  = 3'd5,
      OP_SLTU = 3'd6
   } alu_op_e;

endpackage
